// File: source/render_pkg.sv
package render_pkg;

    // Screen geometry, buffers are stored column-major (x * scr_h + y)
    localparam int scr_w = 320;
    localparam int scr_h = 240;
    localparam int pix_count = 76800;
    localparam int buf_addr_w = 17;

    // Colour word is RR_GG_BB
    localparam int color_w = 6;

    // Sprite ROM holds spr_count sprites of spr_w by spr_h texels.
    // A texel is 7 bits: opacity flag in bit 6 above a colour word.
    // Texels of one sprite are stored column by column.
    localparam int spr_w = 4;
    localparam int spr_h = 4;
    localparam int spr_count = 2;
    localparam int tex_addr_w = 5;

    // Signed width for sprite walk coordinates
    localparam int coord_w = 11;

    // Expands a 2-bit channel to 8 bits (255 / 3)
    localparam int color_scale = 85;

    // CPU register map
    localparam logic [3:0] reg_mid_x = 4'd1;
    localparam logic [3:0] reg_mid_y = 4'd2;
    localparam logic [3:0] reg_neg = 4'd3;
    localparam logic [3:0] reg_tex = 4'd4;
    localparam logic [3:0] reg_parity = 4'd5;
    localparam logic [3:0] reg_plot = 4'd6;
    localparam logic [3:0] reg_flush = 4'd7;

    // Texture code, top bit selects how the low six bits are read
    typedef union packed {
        struct packed {
            logic fill;
            logic [5:0] color;
        } fill_v;
        struct packed {
            logic fill;
            logic [5:0] index;
        } spr_v;
    } tex_code_u;

endpackage

// File: source/plot_cmd_if.sv
interface plot_cmd_if;
    import render_pkg::*;

    // One-cycle launch pulse, fields hold until done
    logic start;
    tex_code_u tex;
    logic signed [coord_w-1:0] mid_x;
    logic signed [coord_w-1:0] mid_y;

    // One-cycle completion pulse from the engine
    logic done;

    modport master (
        output start, output tex, output mid_x, output mid_y,
        input done
    );

    modport slave (
        input start, input tex, input mid_x, input mid_y,
        output done
    );

endinterface

// File: source/render_regs.sv
module render_regs (
    input  logic clk,
    input  logic rst_n,
    input  logic [3:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic waitrequest,
    plot_cmd_if.master cmd,
    output logic flush_start,
    input  logic flush_done
);
    import render_pkg::*;

    logic signed [coord_w-1:0] mid_x;
    logic signed [coord_w-1:0] mid_y;
    logic signed [coord_w-1:0] wr_x;
    logic signed [coord_w-1:0] wr_y;
    logic neg;
    tex_code_u tex;
    logic parity;
    logic wr_ok;
    logic rd_ok;

    assign wr_ok = write && !waitrequest;
    assign rd_ok = read && !waitrequest;

    // Zero-extended coordinate fields from the bus
    assign wr_x = signed'({{(coord_w - 9){1'b0}}, writedata[8:0]});
    assign wr_y = signed'({{(coord_w - 8){1'b0}}, writedata[7:0]});

    assign cmd.mid_x = mid_x;
    assign cmd.mid_y = mid_y;
    assign cmd.tex = tex;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_x <= '0;
            mid_y <= '0;
            neg <= 1'b0;
            tex <= '0;
            parity <= 1'b0;
            waitrequest <= 1'b0;
            readdata <= '0;
            cmd.start <= 1'b0;
            flush_start <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            flush_start <= 1'b0;
            if (flush_done) begin
                parity <= ~parity;
            end
            // Busy ends one cycle after the completion pulse
            if (cmd.done || flush_done) begin
                waitrequest <= 1'b0;
            end
            if (wr_ok) begin
                case (address)
                    reg_mid_x: mid_x <= neg ? -wr_x : wr_x;
                    reg_mid_y: mid_y <= neg ? -wr_y : wr_y;
                    reg_neg: neg <= writedata[0];
                    reg_tex: tex <= writedata[6:0];
                    reg_plot: begin
                        cmd.start <= 1'b1;
                        waitrequest <= 1'b1;
                    end
                    reg_flush: begin
                        flush_start <= 1'b1;
                        waitrequest <= 1'b1;
                    end
                    default: ;
                endcase
            end
            if (rd_ok) begin
                readdata <= (address == reg_parity) ? {31'b0, parity} : '0;
            end
        end
    end

    // No command completes while the bus is idle
    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd.done || flush_done) |-> waitrequest);

endmodule

// File: source/plot_engine.sv
module plot_engine (
    input  logic clk,
    input  logic rst_n,
    plot_cmd_if.slave cmd,
    output logic [render_pkg::tex_addr_w-1:0] tex_addr,
    input  logic [6:0] tex_q,
    output logic buf_wren,
    output logic [render_pkg::buf_addr_w-1:0] buf_addr,
    output logic [render_pkg::color_w-1:0] buf_data
);
    import render_pkg::*;

    logic filling;
    logic walking;
    logic draining;
    logic [buf_addr_w-1:0] fill_addr;
    logic signed [coord_w-1:0] cur_x;
    logic signed [coord_w-1:0] cur_y;
    logic [1:0] col_cnt;
    logic [1:0] row_cnt;
    logic row_last;
    logic on_screen;
    logic [buf_addr_w-1:0] walk_addr;
    logic hold_vld;
    logic [buf_addr_w-1:0] hold_addr;
    logic [tex_addr_w-1:0] spr_base;

    // First texel of the selected sprite
    assign spr_base = tex_addr_w'((cmd.tex.spr_v.index % spr_count) * spr_w * spr_h);

    assign row_last = (row_cnt == 2'(spr_h - 1));

    // Clip against all four screen edges
    assign on_screen = !cur_x[coord_w-1] && (cur_x < coord_w'(scr_w)) &&
                       !cur_y[coord_w-1] && (cur_y < coord_w'(scr_h));

    assign walk_addr = buf_addr_w'(cur_x[8:0]) * buf_addr_w'(scr_h) +
                       buf_addr_w'(cur_y[7:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filling <= 1'b0;
            walking <= 1'b0;
            draining <= 1'b0;
            fill_addr <= '0;
            col_cnt <= '0;
            row_cnt <= '0;
            hold_vld <= 1'b0;
            buf_wren <= 1'b0;
            cmd.done <= 1'b0;
        end else begin
            cmd.done <= 1'b0;
            buf_wren <= 1'b0;
            hold_vld <= 1'b0;
            draining <= 1'b0;
            if (cmd.start) begin
                if (cmd.tex.fill_v.fill) begin
                    filling <= 1'b1;
                    fill_addr <= '0;
                end else begin
                    walking <= 1'b1;
                    col_cnt <= '0;
                    row_cnt <= '0;
                end
            end else if (filling) begin
                buf_wren <= 1'b1;
                fill_addr <= fill_addr + 1'b1;
                if (fill_addr == buf_addr_w'(pix_count - 1)) begin
                    filling <= 1'b0;
                    cmd.done <= 1'b1;
                end
            end else if (walking) begin
                hold_vld <= on_screen;
                if (row_last) begin
                    row_cnt <= '0;
                    col_cnt <= col_cnt + 1'b1;
                    if (col_cnt == 2'(spr_w - 1)) begin
                        walking <= 1'b0;
                        draining <= 1'b1;
                    end
                end else begin
                    row_cnt <= row_cnt + 1'b1;
                end
            end
            // Last texel leaves the ROM while draining
            if (draining) begin
                cmd.done <= 1'b1;
            end
            if (hold_vld && tex_q[6]) begin
                buf_wren <= 1'b1;
            end
        end
    end

    // Walk position and ROM address, screen address waits one cycle for the ROM
    always_ff @(posedge clk) begin
        if (cmd.start) begin
            cur_x <= cmd.mid_x - coord_w'(spr_w / 2);
            cur_y <= cmd.mid_y - coord_w'(spr_h / 2);
            tex_addr <= spr_base;
        end else if (walking) begin
            tex_addr <= tex_addr + 1'b1;
            if (row_last) begin
                cur_x <= cur_x + 1'b1;
                cur_y <= cmd.mid_y - coord_w'(spr_h / 2);
            end else begin
                cur_y <= cur_y + 1'b1;
            end
        end
        hold_addr <= walk_addr;
        if (filling) begin
            buf_addr <= fill_addr;
            buf_data <= cmd.tex.fill_v.color;
        end else begin
            buf_addr <= hold_addr;
            buf_data <= tex_q[color_w-1:0];
        end
    end

    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        buf_wren |-> buf_addr < buf_addr_w'(pix_count));

endmodule

// File: source/sprite_rom.sv
module sprite_rom (
    input  logic clk,
    input  logic [render_pkg::tex_addr_w-1:0] addr,
    output logic [6:0] q
);
    import render_pkg::*;

    logic [6:0] rom [0:(1 << tex_addr_w) - 1];

    // Opacity in bit 6, colour below
    initial begin
        $readmemh("source/sprite_tex.hex", rom);
    end

    always_ff @(posedge clk) begin
        q <= rom[addr];
    end

endmodule

// File: source/frame_store.sv
module frame_store (
    input  logic clk,
    input  logic rst_n,
    input  logic buf_wren,
    input  logic [render_pkg::buf_addr_w-1:0] buf_addr,
    input  logic [render_pkg::color_w-1:0] buf_data,
    input  logic flush_start,
    output logic flush_done,
    input  logic [render_pkg::buf_addr_w-1:0] rd_addr,
    output logic [render_pkg::color_w-1:0] rd_q
);
    import render_pkg::*;

    logic [color_w-1:0] back_mem [0:pix_count-1];
    logic [color_w-1:0] front_mem [0:pix_count-1];

    logic flushing;
    logic [buf_addr_w-1:0] copy_cnt;
    logic [buf_addr_w-1:0] back_addr;
    logic [color_w-1:0] back_q;
    logic copy_vld;
    logic [buf_addr_w-1:0] copy_addr;
    logic wr_en;
    logic [buf_addr_w-1:0] wr_addr;
    logic [color_w-1:0] wr_data;

    // The copier owns the back buffer port during a flush
    assign back_addr = flushing ? copy_cnt : buf_addr;

    always_ff @(posedge clk) begin
        if (buf_wren) begin
            back_mem[back_addr] <= buf_data;
        end
        back_q <= back_mem[back_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flushing <= 1'b0;
            copy_cnt <= '0;
            copy_vld <= 1'b0;
            wr_en <= 1'b0;
            flush_done <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            copy_vld <= 1'b0;
            if (flush_start) begin
                flushing <= 1'b1;
                copy_cnt <= '0;
            end else if (flushing) begin
                copy_vld <= 1'b1;
                if (copy_cnt == buf_addr_w'(pix_count - 1)) begin
                    flushing <= 1'b0;
                end else begin
                    copy_cnt <= copy_cnt + 1'b1;
                end
            end
            wr_en <= copy_vld;
            if (wr_en && wr_addr == buf_addr_w'(pix_count - 1)) begin
                flush_done <= 1'b1;
            end
        end
    end

    // Write side trails the read address by two cycles
    always_ff @(posedge clk) begin
        copy_addr <= copy_cnt;
        wr_addr <= copy_addr;
        wr_data <= back_q;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            front_mem[wr_addr] <= wr_data;
        end
        rd_q <= front_mem[rd_addr];
    end

    a_no_plot_in_flush: assert property (@(posedge clk) disable iff (!rst_n)
        flushing |-> !buf_wren);

endmodule

// File: source/pixel_out.sv
module pixel_out (
    input  logic clk,
    input  logic rst_n,
    input  logic [8:0] pixel_x,
    input  logic [7:0] pixel_y,
    output logic [render_pkg::buf_addr_w-1:0] rd_addr,
    input  logic [render_pkg::color_w-1:0] rd_q,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);
    import render_pkg::*;

    // Column-major lookup, data returns from the front buffer next cycle
    assign rd_addr = buf_addr_w'(pixel_x) * buf_addr_w'(scr_h) + buf_addr_w'(pixel_y);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red <= '0;
            green <= '0;
            blue <= '0;
        end else begin
            red <= 8'(rd_q[5:4] * color_scale);
            green <= 8'(rd_q[3:2] * color_scale);
            blue <= 8'(rd_q[1:0] * color_scale);
        end
    end

endmodule

// File: source/render_top.sv
module render_top (
    input  logic clk,
    input  logic rst_n,
    input  logic [3:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic waitrequest,
    input  logic [8:0] pixel_x,
    input  logic [7:0] pixel_y,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);
    import render_pkg::*;

    logic [tex_addr_w-1:0] tex_addr;
    logic [6:0] tex_q;
    logic buf_wren;
    logic [buf_addr_w-1:0] buf_addr;
    logic [color_w-1:0] buf_data;
    logic flush_start;
    logic flush_done;
    logic [buf_addr_w-1:0] rd_addr;
    logic [color_w-1:0] rd_q;

    plot_cmd_if cmd_bus ();

    render_regs u_regs (
        .clk(clk), .rst_n(rst_n),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .readdata(readdata), .waitrequest(waitrequest),
        .cmd(cmd_bus.master),
        .flush_start(flush_start), .flush_done(flush_done)
    );

    plot_engine u_engine (
        .clk(clk), .rst_n(rst_n),
        .cmd(cmd_bus.slave),
        .tex_addr(tex_addr), .tex_q(tex_q),
        .buf_wren(buf_wren), .buf_addr(buf_addr), .buf_data(buf_data)
    );

    sprite_rom u_rom (
        .clk(clk), .addr(tex_addr), .q(tex_q)
    );

    frame_store u_store (
        .clk(clk), .rst_n(rst_n),
        .buf_wren(buf_wren), .buf_addr(buf_addr), .buf_data(buf_data),
        .flush_start(flush_start), .flush_done(flush_done),
        .rd_addr(rd_addr), .rd_q(rd_q)
    );

    pixel_out u_pixel (
        .clk(clk), .rst_n(rst_n),
        .pixel_x(pixel_x), .pixel_y(pixel_y),
        .rd_addr(rd_addr), .rd_q(rd_q),
        .red(red), .green(green), .blue(blue)
    );

endmodule

// File: dv/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int period = 10,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // Reset is released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: dv/render_tb.sv
module render_tb;
    import render_pkg::*;

    localparam int reset_cycles = 8;
    localparam int n_cmds = 12;
    localparam int cycle_limit = reset_cycles + n_cmds * (pix_count + 100) + 2000;

    logic clk;
    logic rst_n;
    logic [3:0] address;
    logic read;
    logic write;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic waitrequest;
    logic [8:0] pixel_x;
    logic [7:0] pixel_y;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    // Expected values travel with the stimulus they belong to
    logic chk_vld;
    logic [7:0] exp_r;
    logic [7:0] exp_g;
    logic [7:0] exp_b;
    logic [31:0] exp_rd;
    logic cmd_accept;
    logic done_any;

    int errors = 0;
    int n_checks = 0;
    int cycles = 0;
    logic [31:0] rng_state = 32'd96;
    logic [6:0] tex_mem [0:31];

    // Reference model of the registers and both buffers
    logic neg_m;
    logic [6:0] tex_m;
    int mid_x_m;
    int mid_y_m;
    int flushes;
    logic [5:0] back_fill;
    logic [5:0] front_fill;
    int back_idx[$];
    int back_mx[$];
    int back_my[$];
    int front_idx[$];
    int front_mx[$];
    int front_my[$];

    tb_clk_gen #(.period(10), .reset_cycles(reset_cycles)) clk_gen (
        .clk(clk), .rst_n(rst_n)
    );

    render_top UUT (
        .clk(clk), .rst_n(rst_n),
        .address(address), .read(read), .write(write),
        .writedata(writedata), .readdata(readdata), .waitrequest(waitrequest),
        .pixel_x(pixel_x), .pixel_y(pixel_y),
        .red(red), .green(green), .blue(blue)
    );

    assign cmd_accept = write && !waitrequest &&
                        (address == reg_plot || address == reg_flush);
    assign done_any = UUT.flush_done || UUT.cmd_bus.done;

    function automatic int next_rand(input int range);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'(rng_state[30:16]) % range;
    endfunction

    function automatic logic [7:0] chan_level(input logic [1:0] f);
        case (f)
            2'd0: return 8'd0;
            2'd1: return 8'd85;
            2'd2: return 8'd170;
            default: return 8'd255;
        endcase
    endfunction

    // Later sprites cover earlier ones, transparent texels leave the pixel alone
    function automatic logic [5:0] front_color(input int x, input int y);
        logic [5:0] c;
        logic [6:0] t;
        int col;
        int row;
        c = front_fill;
        for (int i = 0; i < front_idx.size(); i++) begin
            col = x - (front_mx[i] - spr_w / 2);
            row = y - (front_my[i] - spr_h / 2);
            if (col >= 0 && col < spr_w && row >= 0 && row < spr_h) begin
                t = tex_mem[front_idx[i] * spr_w * spr_h + col * spr_h + row];
                if (t[6]) begin
                    c = t[5:0];
                end
            end
        end
        return c;
    endfunction

    // Holds the request until accepted, then updates the model
    task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
        address <= a;
        writedata <= d;
        write <= 1'b1;
        do @(posedge clk); while (waitrequest);
        write <= 1'b0;
        case (a)
            reg_mid_x: mid_x_m = neg_m ? -int'(d[8:0]) : int'(d[8:0]);
            reg_mid_y: mid_y_m = neg_m ? -int'(d[7:0]) : int'(d[7:0]);
            reg_neg: neg_m = d[0];
            reg_tex: tex_m = d[6:0];
            reg_plot: begin
                if (tex_m[6]) begin
                    back_fill = tex_m[5:0];
                    back_idx.delete();
                    back_mx.delete();
                    back_my.delete();
                end else begin
                    back_idx.push_back(int'(tex_m[5:0]) % spr_count);
                    back_mx.push_back(mid_x_m);
                    back_my.push_back(mid_y_m);
                end
            end
            reg_flush: begin
                front_fill = back_fill;
                front_idx = back_idx;
                front_mx = back_mx;
                front_my = back_my;
                flushes++;
            end
            default: ;
        endcase
    endtask

    task automatic bus_read(input logic [3:0] a);
        address <= a;
        read <= 1'b1;
        exp_rd <= (a == reg_parity) ? 32'(flushes % 2) : 32'd0;
        n_checks++;
        do @(posedge clk); while (waitrequest);
        read <= 1'b0;
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (waitrequest);
    endtask

    task automatic run_cmd(input logic [3:0] a);
        bus_write(a, 32'd0);
        wait_idle();
    endtask

    task automatic probe(input int x, input int y);
        logic [5:0] c;
        c = front_color(x, y);
        pixel_x <= 9'(x);
        pixel_y <= 8'(y);
        exp_r <= chan_level(c[5:4]);
        exp_g <= chan_level(c[3:2]);
        exp_b <= chan_level(c[1:0]);
        chk_vld <= 1'b1;
        n_checks++;
        @(posedge clk);
    endtask

    // Lets the last coordinates reach the colour outputs
    task automatic end_probes();
        chk_vld <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic probe_random(input int n);
        for (int i = 0; i < n; i++) begin
            probe(next_rand(scr_w), next_rand(scr_h));
        end
        end_probes();
    endtask

    task automatic probe_window(input int x0, input int y0, input int w, input int h);
        for (int x = x0; x < x0 + w; x++) begin
            for (int y = y0; y < y0 + h; y++) begin
                probe(x, y);
            end
        end
        end_probes();
    endtask

    a_colour: assert property (@(posedge clk) disable iff (!rst_n)
        $past(chk_vld, 2) |-> (red == $past(exp_r, 2) && green == $past(exp_g, 2) &&
                               blue == $past(exp_b, 2)))
        else begin
            errors++;
            $display("Fail %0t: scan-out colour r %0d g %0d b %0d is wrong",
                     $time, red, green, blue);
        end

    a_readdata: assert property (@(posedge clk) disable iff (!rst_n)
        $past(read && !waitrequest) |-> readdata == $past(exp_rd))
        else begin
            errors++;
            $display("Fail %0t: readdata %0h is wrong", $time, readdata);
        end

    a_wait_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $past(cmd_accept) |-> waitrequest)
        else begin
            errors++;
            $display("Fail %0t: waitrequest did not rise after a command", $time);
        end

    a_wait_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $past(waitrequest && !done_any) |-> waitrequest)
        else begin
            errors++;
            $display("Fail %0t: waitrequest fell before the command completed", $time);
        end

    a_wait_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $past(waitrequest && done_any) |-> !waitrequest)
        else begin
            errors++;
            $display("Fail %0t: waitrequest stayed high after completion", $time);
        end

    a_wait_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $past(!waitrequest && !cmd_accept) |-> !waitrequest)
        else begin
            errors++;
            $display("Fail %0t: waitrequest rose without a command", $time);
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, a command never completed", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        address <= '0;
        read <= 1'b0;
        write <= 1'b0;
        writedata <= '0;
        pixel_x <= '0;
        pixel_y <= '0;
        chk_vld <= 1'b0;
        exp_r <= '0;
        exp_g <= '0;
        exp_b <= '0;
        exp_rd <= '0;
        neg_m = 1'b0;
        tex_m = '0;
        mid_x_m = 0;
        mid_y_m = 0;
        flushes = 0;
        back_fill = '0;
        front_fill = '0;
        $readmemh("source/sprite_tex.hex", tex_mem);
        do @(posedge clk); while (!rst_n);

        // Idle bus and cleared parity after reset
        check_idle: assert (!waitrequest) else begin
            errors++;
            $display("Fail %0t: waitrequest high after reset", $time);
        end
        bus_read(reg_parity);

        // Fill and flush, then random scan-out
        bus_write(reg_tex, 32'h40 | 32'h1b);
        run_cmd(reg_plot);
        run_cmd(reg_flush);
        bus_read(reg_parity);
        probe_random(40);

        // Second flush returns parity to zero
        run_cmd(reg_flush);
        bus_read(reg_parity);

        // Sprite 1 over a fresh fill
        bus_write(reg_tex, 32'h40 | 32'h05);
        run_cmd(reg_plot);
        bus_write(reg_mid_x, 32'd100);
        bus_write(reg_mid_y, 32'd60);
        // A written coordinate register still reads as zero
        bus_read(reg_mid_x);
        bus_write(reg_tex, 32'd1);
        run_cmd(reg_plot);
        run_cmd(reg_flush);
        probe_window(97, 57, 6, 6);

        // Sprite 0 at centre x -1 is clipped at the left edge and must not wrap
        bus_write(reg_neg, 32'd1);
        bus_write(reg_mid_x, 32'd1);
        bus_write(reg_neg, 32'd0);
        bus_write(reg_mid_y, 32'd120);
        bus_write(reg_tex, 32'd0);
        run_cmd(reg_plot);
        run_cmd(reg_flush);
        probe_window(0, 117, 3, 6);
        probe_window(316, 117, 4, 6);

        // Texture write stalls behind a busy fill
        bus_write(reg_tex, 32'h40 | 32'h30);
        bus_write(reg_plot, 32'd0);
        bus_write(reg_tex, 32'h40 | 32'h0c);
        run_cmd(reg_flush);
        probe_random(20);
        run_cmd(reg_plot);
        run_cmd(reg_flush);
        probe_random(20);
        bus_read(reg_parity);
        repeat (2) @(posedge clk);

        $display("Checks %0d, errors %0d", n_checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: source/sprite_tex.hex
// One texel per line: bit 6 opaque, bits 5:0 colour RR_GG_BB, column by column
70
4c
43
00
7f
2a
55
6a
41
42
44
48
00
7c
73
4f
00
63
63
00
63
7f
7f
63
15
7f
7f
63
00
63
63
00

// File: project.f
source/render_pkg.sv
source/plot_cmd_if.sv
source/render_regs.sv
source/plot_engine.sv
source/sprite_rom.sv
source/frame_store.sv
source/pixel_out.sv
source/render_top.sv
dv/tb_clk_gen.sv
dv/render_tb.sv

// File: run.sh
#!/bin/sh
# Build the renderer testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module render_tb -f project.f -o render_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/render_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
